// ==== Makefile ====
# Verilator simulation of the instruction cache

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if the log shows the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== icache_ctrl.sv ====
// icache controller
module icache_ctrl import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       flush_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output logic       rsp_valid_o,
  output logic       busy_o,
  output logic       miss_o,
  output logic       mem_req_o,
  input  logic       mem_ack_i,
  output mem_req_t   mem_req_data_o,
  input  logic       mem_rtrn_vld_i,
  input  mem_rtrn_t  mem_rtrn_i,
  input  way_mask_t  hit_i,
  input  way_t       victim_i,
  input  logic       all_valid_i,
  output way_mask_t  tag_req_o,
  output logic       tag_we_o,
  output set_idx_t   tag_addr_o,
  output tag_t       tag_wdata_o,
  output logic       valid_wdata_o,
  output way_mask_t  data_req_o,
  output logic       data_we_o,
  output set_idx_t   data_addr_o,
  output offset_t    offset_o,
  output logic       use_array_o,
  output logic       lfsr_step_o
);

  ctrl_state_e state_d, state_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  logic        flush_pend;
  logic        start_flush;
  logic        inv_en, inv_q;
  logic        fill_en;
  // arrays were read last cycle, compare this cycle
  logic        cmp_en_d, cmp_en_q;
  logic        nc_d, nc_q;
  paddr_t      paddr_d, paddr_q;
  set_idx_t    index_d;
  set_idx_t    flush_cnt_d, flush_cnt_q;
  logic        flush_en, flush_done;
  way_mask_t   victim_oh_d, victim_oh_q;
  way_t        victim_bin;
  logic        repl_all_d, repl_all_q;
  logic        accept, hit_ok;
  logic        cache_rden, cache_wren;

  ////////////////////////////////////////////////////////////
  // request address and flags
  ////////////////////////////////////////////////////////////

  assign accept  = fetch_ready_o & fetch_req_i.req;
  assign paddr_d = accept ? fetch_req_i.paddr : paddr_q;
  assign index_d = paddr_d[OFFSET_W +: INDEX_W];
  // uncached when in the i/o region or while disabled, fixed per request
  assign nc_d    = accept ? (~cache_en_q | fetch_req_i.paddr[NC_BIT]) : nc_q;

  assign tag_wdata_o = paddr_q[PADDR_W-1 -: TAG_W];
  assign offset_o    = paddr_q[OFFSET_W-1:0];

  // word address for uncached reads, line address for fills
  assign mem_req_data_o.paddr = nc_q ? {paddr_q[PADDR_W-1:2], 2'b00} :
                                       {paddr_q[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_req_data_o.nc    = nc_q;
  assign mem_req_data_o.way   = cmp_en_q ? victim_i : victim_bin;

  // return port decode, fills and invalidations never coincide
  assign inv_en  = mem_rtrn_vld_i & (mem_rtrn_i.rtype == INV_REQ);
  assign fill_en = mem_rtrn_vld_i & (mem_rtrn_i.rtype == IFILL_ACK);

  assign flush_pend  = flush_q | flush_i;
  // enabling always goes through a full flush
  assign start_flush = flush_pend | (en_i & ~cache_en_q);

  // a hit is only trusted once the arrays were re-read after an invalidation
  assign hit_ok = cmp_en_q & ~inv_q & (|hit_i);

  assign fetch_ready_o = ~start_flush & ~mem_rtrn_vld_i &
                         ((state_q == IDLE) | ((state_q == READ) & hit_ok));

  assign busy_o      = (state_q == FLUSH);
  assign use_array_o = cmp_en_q;

  ////////////////////////////////////////////////////////////
  // main state machine
  ////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d     = state_q;
    cache_en_d  = cache_en_q & en_i;
    flush_d     = flush_pend;
    cmp_en_d    = 1'b0;
    cache_rden  = 1'b0;
    cache_wren  = 1'b0;
    flush_en    = 1'b0;
    rsp_valid_o = 1'b0;
    mem_req_o   = 1'b0;
    miss_o      = 1'b0;

    unique case (state_q)
      // walk all sets and clear their valid bits
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (start_flush) begin
          state_d = FLUSH;
        end else if (accept) begin
          cache_rden = 1'b1;
          cmp_en_d   = cache_en_q;
          state_d    = READ;
        end
      end
      READ: begin
        if (cmp_en_q && inv_q) begin
          // tag port was busy with the invalidation, read again
          cache_rden = cache_en_q;
          cmp_en_d   = cache_en_q;
        end else if (hit_ok) begin
          rsp_valid_o = 1'b1;
          state_d     = IDLE;
          // stream the next request straight into a lookup
          if (accept) begin
            cache_rden = 1'b1;
            cmp_en_d   = cache_en_q;
            state_d    = READ;
          end
        end else begin
          // miss or uncached, hold the request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        if (fill_en) begin
          rsp_valid_o = 1'b1;
          // uncached data is passed on but never allocated
          cache_wren  = ~nc_q;
          state_d     = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // flush counter, replacement and array control
  ////////////////////////////////////////////////////////////

  assign flush_done  = (flush_cnt_q == set_idx_t'(NUM_SETS - 1));
  assign flush_cnt_d = flush_done ? '0 :
                       flush_en   ? flush_cnt_q + 1'b1 :
                                    flush_cnt_q;

  // victim is sampled while the valid bits of the looked up set are on the bus
  assign victim_oh_d = cmp_en_q ? (way_mask_t'(1'b1) << victim_i) : victim_oh_q;
  assign repl_all_d  = cmp_en_q ? all_valid_i : repl_all_q;

  always_comb begin : p_victim_bin
    victim_bin = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (victim_oh_q[i]) begin
        victim_bin = way_t'(i);
      end
    end
  end

  // flush wins over invalidation, the whole cache is cleared anyway
  assign tag_addr_o    = flush_en ? flush_cnt_q :
                         inv_en   ? mem_rtrn_i.inv_idx :
                                    index_d;
  assign tag_req_o     = (flush_en | inv_en | cache_rden) ? '1 :
                         cache_wren                       ? victim_oh_q :
                                                            '0;
  assign tag_we_o      = flush_en | inv_en | cache_wren;
  assign valid_wdata_o = cache_wren;

  assign data_req_o  = cache_rden ? '1 :
                       cache_wren ? victim_oh_q :
                                    '0;
  assign data_we_o   = cache_wren;
  assign data_addr_o = index_d;

  // random replacement only moves on when it was actually used
  assign lfsr_step_o = cache_wren & repl_all_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      inv_q       <= 1'b0;
      cmp_en_q    <= 1'b0;
      nc_q        <= 1'b0;
      flush_cnt_q <= '0;
      victim_oh_q <= '0;
      repl_all_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      inv_q       <= inv_en;
      cmp_en_q    <= cmp_en_d;
      nc_q        <= nc_d;
      flush_cnt_q <= flush_cnt_d;
      victim_oh_q <= victim_oh_d;
      repl_all_q  <= repl_all_d;
    end
  end

  // request address
  always_ff @(posedge clk_i) begin : p_addr
    paddr_q <= paddr_d;
  end

endmodule

// ==== icache_hit_sel.sv ====
// tag compare and word select
module icache_hit_sel import icache_pkg::*; (
  input  tag_t  [NUM_WAYS-1:0] tag_rdata_i,
  input  way_mask_t            valid_rdata_i,
  input  line_t [NUM_WAYS-1:0] line_rdata_i,
  input  tag_t                 ref_tag_i,
  input  offset_t              offset_i,
  input  logic                 use_array_i,
  input  line_t                fill_line_i,
  output way_mask_t            hit_o,
  output word_t                word_o
);

  way_t                hit_way;
  logic [OFFSET_W-3:0] word_idx;
  word_t               array_word;
  word_t               fill_word;

  // a way hits only with a valid entry and a matching tag
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign hit_o[w] = valid_rdata_i[w] & (tag_rdata_i[w] == ref_tag_i);
  end

  // lowest hitting way, there should never be more than one
  always_comb begin : p_hit_way
    hit_way = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (hit_o[i]) begin
        hit_way = way_t'(i);
      end
    end
  end

  // fetches are word aligned, low two offset bits are ignored
  assign word_idx = offset_i[OFFSET_W-1:2];

  assign array_word = line_rdata_i[hit_way][word_idx*FETCH_W +: FETCH_W];
  assign fill_word  = fill_line_i[word_idx*FETCH_W +: FETCH_W];

  // refill data bypasses the arrays on a miss
  assign word_o = use_array_i ? array_word : fill_word;

endmodule

// ==== icache_mem.sv ====
// icache tag and data arrays
module icache_mem import icache_pkg::*; (
  input  logic                      clk_i,
  // tag + valid port
  input  way_mask_t                 tag_req_i,
  input  logic                      tag_we_i,
  input  set_idx_t                  tag_addr_i,
  input  tag_t                      tag_wdata_i,
  input  logic                      valid_wdata_i,
  // line port
  input  way_mask_t                 data_req_i,
  input  logic                      data_we_i,
  input  set_idx_t                  data_addr_i,
  input  line_t                     data_wdata_i,
  // read data, one cycle after the request
  output tag_t  [NUM_WAYS-1:0]      tag_rdata_o,
  output way_mask_t                 valid_rdata_o,
  output line_t [NUM_WAYS-1:0]      line_rdata_o
);

  ////////////////////////////////////////////////////////////
  // one tag and one line memory per way
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    // valid bit sits on top of the tag
    logic [TAG_W:0] tag_mem [NUM_SETS];
    logic [TAG_W:0] tag_rd_q;
    line_t          data_mem [NUM_SETS];
    line_t          data_rd_q;

    // single port, a write leaves the read register untouched
    always_ff @(posedge clk_i) begin : p_tag
      if (tag_req_i[w]) begin
        if (tag_we_i) begin
          tag_mem[tag_addr_i] <= {valid_wdata_i, tag_wdata_i};
        end else begin
          tag_rd_q <= tag_mem[tag_addr_i];
        end
      end
    end

    always_ff @(posedge clk_i) begin : p_data
      if (data_req_i[w]) begin
        if (data_we_i) begin
          data_mem[data_addr_i] <= data_wdata_i;
        end else begin
          data_rd_q <= data_mem[data_addr_i];
        end
      end
    end

    // split the stored entry again
    assign tag_rdata_o[w]   = tag_rd_q[TAG_W-1:0];
    assign valid_rdata_o[w] = tag_rd_q[TAG_W];
    assign line_rdata_o[w]  = data_rd_q;
  end

endmodule

// ==== icache_pkg.sv ====
// instruction cache definitions
package icache_pkg;

  ////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned PADDR_W  = 32;
  localparam int unsigned FETCH_W  = 32;
  localparam int unsigned LINE_W   = 128;
  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned NUM_SETS = 16;
  localparam int unsigned OFFSET_W = 4;
  localparam int unsigned INDEX_W  = 4;
  // tag is whatever is left above index and offset
  localparam int unsigned TAG_W    = PADDR_W - INDEX_W - OFFSET_W;
  localparam int unsigned WAY_W    = 2;
  // upper half of the address space is the uncached i/o region
  localparam int unsigned NC_BIT   = 31;

  // address fields and payload widths
  typedef logic [PADDR_W-1:0]  paddr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  set_idx_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [WAY_W-1:0]    way_t;
  typedef logic [NUM_WAYS-1:0] way_mask_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [FETCH_W-1:0]  word_t;

  // fills and invalidations share the return port
  typedef enum logic {
    IFILL_ACK,
    INV_REQ
  } rtrn_type_e;

  // controller states, also seen by the bound checker
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////
  // port bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic   req;
    paddr_t paddr;
  } fetch_req_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } fetch_rsp_t;

  // refill request, way tells memory which victim gets the line
  typedef struct packed {
    paddr_t paddr;
    logic   nc;
    way_t   way;
  } mem_req_t;

  typedef struct packed {
    rtrn_type_e rtype;
    set_idx_t   inv_idx;
    line_t      data;
  } mem_rtrn_t;

endpackage

// ==== icache_repl.sv ====
// victim way selection
module icache_repl import icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  way_mask_t valid_i,
  input  logic      step_i,
  output way_t      victim_o,
  output logic      all_valid_o
);

  way_t       inv_way;
  logic [7:0] lfsr_q;
  logic       lfsr_fb;

  // lowest numbered free way
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        inv_way = way_t'(i);
      end
    end
  end

  assign all_valid_o = &valid_i;

  // taps for x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // free ways first, random pick once the set is full
  assign victim_o = all_valid_o ? lfsr_q[WAY_W-1:0] : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      // any nonzero seed
      lfsr_q <= 8'ha5;
    end else if (step_i) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

endmodule

// ==== icache_top.sv ====
// instruction cache top
module icache_top import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // core side
  input  fetch_req_t fetch_req_i,
  input  logic       en_i,
  input  logic       flush_i,
  output logic       fetch_ready_o,
  output fetch_rsp_t fetch_rsp_o,
  output logic       busy_o,
  output logic       miss_o,
  // refill request
  output logic       mem_req_o,
  input  logic       mem_ack_i,
  output mem_req_t   mem_req_data_o,
  // fill and invalidation return
  input  logic       mem_rtrn_vld_i,
  input  mem_rtrn_t  mem_rtrn_i
);

  logic                 rsp_valid;
  word_t                rsp_word;
  way_mask_t            hit;
  way_t                 victim;
  logic                 all_valid;
  logic                 lfsr_step;
  way_mask_t            tag_req;
  logic                 tag_we;
  set_idx_t             tag_addr;
  tag_t                 tag_wdata;
  logic                 valid_wdata;
  way_mask_t            data_req;
  logic                 data_we;
  set_idx_t             data_addr;
  offset_t              offset;
  logic                 use_array;
  tag_t  [NUM_WAYS-1:0] tag_rdata;
  way_mask_t            valid_rdata;
  line_t [NUM_WAYS-1:0] line_rdata;

  assign fetch_rsp_o = '{valid: rsp_valid, data: rsp_word};

  ////////////////////////////////////////////////////////////
  // controller and replacement
  ////////////////////////////////////////////////////////////

  icache_ctrl i_icache_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .en_i           ( en_i           ),
    .flush_i        ( flush_i        ),
    .fetch_req_i    ( fetch_req_i    ),
    .fetch_ready_o  ( fetch_ready_o  ),
    .rsp_valid_o    ( rsp_valid      ),
    .busy_o         ( busy_o         ),
    .miss_o         ( miss_o         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_req_data_o ( mem_req_data_o ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_rtrn_i     ( mem_rtrn_i     ),
    .hit_i          ( hit            ),
    .victim_i       ( victim         ),
    .all_valid_i    ( all_valid      ),
    .tag_req_o      ( tag_req        ),
    .tag_we_o       ( tag_we         ),
    .tag_addr_o     ( tag_addr       ),
    .tag_wdata_o    ( tag_wdata      ),
    .valid_wdata_o  ( valid_wdata    ),
    .data_req_o     ( data_req       ),
    .data_we_o      ( data_we        ),
    .data_addr_o    ( data_addr      ),
    .offset_o       ( offset         ),
    .use_array_o    ( use_array      ),
    .lfsr_step_o    ( lfsr_step      )
  );

  icache_repl i_icache_repl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .valid_i     ( valid_rdata ),
    .step_i      ( lfsr_step   ),
    .victim_o    ( victim      ),
    .all_valid_o ( all_valid   )
  );

  ////////////////////////////////////////////////////////////
  // arrays and hit path
  ////////////////////////////////////////////////////////////

  // refill line goes straight from the return port into the arrays
  icache_mem i_icache_mem (
    .clk_i         ( clk_i           ),
    .tag_req_i     ( tag_req         ),
    .tag_we_i      ( tag_we          ),
    .tag_addr_i    ( tag_addr        ),
    .tag_wdata_i   ( tag_wdata       ),
    .valid_wdata_i ( valid_wdata     ),
    .data_req_i    ( data_req        ),
    .data_we_i     ( data_we         ),
    .data_addr_i   ( data_addr       ),
    .data_wdata_i  ( mem_rtrn_i.data ),
    .tag_rdata_o   ( tag_rdata       ),
    .valid_rdata_o ( valid_rdata     ),
    .line_rdata_o  ( line_rdata      )
  );

  // the registered request tag doubles as compare reference
  icache_hit_sel i_icache_hit_sel (
    .tag_rdata_i   ( tag_rdata       ),
    .valid_rdata_i ( valid_rdata     ),
    .line_rdata_i  ( line_rdata      ),
    .ref_tag_i     ( tag_wdata       ),
    .offset_i      ( offset          ),
    .use_array_i   ( use_array       ),
    .fill_line_i   ( mem_rtrn_i.data ),
    .hit_o         ( hit             ),
    .word_o        ( rsp_word        )
  );

endmodule

// ==== sim.f ====
icache_pkg.sv
icache_ctrl.sv
icache_repl.sv
icache_mem.sv
icache_hit_sel.sv
icache_top.sv
tb_icache_sva.sv
tb_icache.sv

// ==== tb_icache.sv ====
// icache testbench
module tb_icache import icache_pkg::*; ();

  typedef enum logic [1:0] {OP_FETCH, OP_FLUSH, OP_INV, OP_EN} op_e;

  // one stimulus row, addr doubles as index or enable value
  typedef struct packed {
    op_e    op;
    paddr_t addr;
    logic   exp_miss;
    logic   dont_care;
  } entry_t;

  logic       clk_i;
  logic       rst_ni;
  fetch_req_t fetch_req_i;
  logic       en_i;
  logic       flush_i;
  logic       fetch_ready_o;
  fetch_rsp_t fetch_rsp_o;
  logic       busy_o;
  logic       miss_o;
  logic       mem_req_o;
  logic       mem_ack_i;
  mem_req_t   mem_req_data_o;
  logic       mem_rtrn_vld_i;
  mem_rtrn_t  mem_rtrn_i;

  entry_t      table_q [$];
  int unsigned rng_state = 32'h2912;
  int          errors, req_cnt, miss_cnt, nc_cnt, cycles, limit;
  logic        en_model;
  // victim way seen on the last refill request
  way_t        req_way;
  // lines filled per set since the last flush, free ways go first
  int          fills [NUM_SETS];
  // memory model state
  int          mstate, delay;
  paddr_t      fill_addr;
  logic        inv_go;
  set_idx_t    inv_idx_r;

  icache_top i_icache_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;
  endfunction

  // word at byte address a is a ^ 5a5a0000
  function automatic line_t make_line(paddr_t a);
    line_t  l;
    paddr_t base;
    base = {a[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    for (int i = 0; i < 4; i++) begin
      l[i*FETCH_W +: FETCH_W] = (base + paddr_t'(4 * i)) ^ 32'h5a5a_0000;
    end
    return l;
  endfunction

  ////////////////////////////////////////////////////////////
  // memory model and monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    if (!rst_ni) begin
      mstate = 0;
    end else if (mstate == 0 && inv_go) begin
      mem_rtrn_vld_i = 1'b1;
      mem_rtrn_i     = '{rtype: INV_REQ, inv_idx: inv_idx_r, data: '0};
      inv_go         = 1'b0;
    end else if (mstate == 0 && mem_req_o) begin
      delay  = lcg_next() % 4;
      mstate = 1;
    end else if (mstate == 1) begin
      delay = delay - 1;
    end else if (mstate == 2) begin
      delay = delay - 1;
      if (delay == 0) begin
        mem_rtrn_vld_i = 1'b1;
        mem_rtrn_i     = '{rtype: IFILL_ACK, inv_idx: '0, data: make_line(fill_addr)};
        mstate         = 0;
      end
    end
    // acknowledge once the random wait ran out
    if (mstate == 1 && delay <= 0) begin
      mem_ack_i = 1'b1;
      fill_addr = mem_req_data_o.paddr;
      delay     = 1 + lcg_next() % 6;
      mstate    = 2;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles++;
      req_cnt  += mem_req_o;
      nc_cnt   += mem_req_o & mem_req_data_o.nc;
      miss_cnt += miss_o;
      if (mem_req_o) begin
        req_way = mem_req_data_o.way;
      end
      if (limit > 0 && cycles > limit) begin
        $display("timeout, no progress after %0d cycles", cycles);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic add(op_e op, paddr_t addr, logic miss, logic dc);
    table_q.push_back('{op: op, addr: addr, exp_miss: miss, dont_care: dc});
  endtask

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // flush runs for exactly one cycle per set
  task automatic wait_flush();
    int n;
    n = 0;
    do @(posedge clk_i); while (!busy_o);
    while (busy_o) begin
      n++;
      @(posedge clk_i);
    end
    check_val("busy_o cycles", n, NUM_SETS);
    // a flush empties every set
    foreach (fills[s]) begin
      fills[s] = 0;
    end
  endtask

  task automatic do_fetch(entry_t e);
    int       r0, m0, n0;
    logic     nc, rose;
    word_t    data;
    set_idx_t idx;
    r0 = req_cnt;
    m0 = miss_cnt;
    n0 = nc_cnt;
    @(negedge clk_i);
    fetch_req_i = '{req: 1'b1, paddr: e.addr};
    do @(posedge clk_i); while (!fetch_ready_o);
    @(negedge clk_i);
    fetch_req_i.req = 1'b0;
    do @(posedge clk_i); while (!fetch_rsp_o.valid);
    data = fetch_rsp_o.data;
    @(negedge clk_i);
    nc   = e.addr[NC_BIT] | ~en_model;
    rose = (req_cnt != r0);
    idx  = e.addr[OFFSET_W +: INDEX_W];
    check_val("fetch_rsp_o.data", data, e.addr ^ 32'h5a5a_0000);
    if (nc) begin
      // uncached goes to memory every time and is never a miss
      check_val("mem_req_o", rose, 1);
      check_val("mem_req_data_o.nc", nc_cnt != n0, 1);
      check_val("miss_o", miss_cnt - m0, 0);
    end else if (!e.dont_care) begin
      check_val("mem_req_o", rose, e.exp_miss);
      check_val("miss_o", miss_cnt - m0, e.exp_miss);
      // a set with free ways fills from way 0 upward
      if (e.exp_miss && rose) begin
        check_val("mem_req_data_o.way", req_way, fills[idx]);
      end
    end else begin
      check_val("miss_o", miss_cnt - m0, rose);
    end
    if (!nc && rose && fills[idx] < NUM_WAYS) begin
      fills[idx]++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int e0;
    rst_ni = 1'b0;
    fetch_req_i = '0;
    en_i = 1'b0;
    flush_i = 1'b0;
    mem_ack_i = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i = '0;
    inv_go = 1'b0;
    en_model = 1'b0;
    errors = 0;
    cycles = 0;
    limit = 0;
    add(OP_EN, 1, 0, 0);
    add(OP_FETCH, 32'h0000_1000, 1, 0);
    add(OP_FETCH, 32'h0000_100c, 0, 0);
    add(OP_FETCH, 32'h0000_2010, 1, 0);
    add(OP_FETCH, 32'h0000_2018, 0, 0);
    add(OP_FETCH, 32'h8000_1000, 1, 0);
    add(OP_FETCH, 32'h8000_1000, 1, 0);
    add(OP_FLUSH, 0, 0, 0);
    add(OP_FETCH, 32'h0000_1004, 1, 0);
    add(OP_FETCH, 32'h0000_2014, 1, 0);
    add(OP_INV, 0, 0, 0);
    add(OP_FETCH, 32'h0000_1000, 1, 0);
    add(OP_FETCH, 32'h0000_2010, 0, 0);
    // five tags at index 2, four free ways first
    add(OP_FETCH, 32'h0000_3020, 1, 0);
    add(OP_FETCH, 32'h0000_4020, 1, 0);
    add(OP_FETCH, 32'h0000_5020, 1, 0);
    add(OP_FETCH, 32'h0000_6020, 1, 0);
    add(OP_FETCH, 32'h0000_7020, 0, 1);
    add(OP_FETCH, 32'h0000_3024, 0, 1);
    add(OP_FETCH, 32'h0000_4028, 0, 1);
    add(OP_FETCH, 32'h0000_702c, 0, 1);
    add(OP_EN, 0, 0, 0);
    add(OP_FETCH, 32'h0000_2010, 1, 0);
    add(OP_EN, 1, 0, 0);
    add(OP_FETCH, 32'h0000_2010, 1, 0);
    add(OP_FETCH, 32'h0000_2010, 0, 0);
    limit = table_q.size() * 20;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (table_q[i]) begin
      e0 = errors;
      case (table_q[i].op)
        OP_FETCH: do_fetch(table_q[i]);
        OP_FLUSH: begin
          @(negedge clk_i);
          flush_i = 1'b1;
          @(negedge clk_i);
          flush_i = 1'b0;
          wait_flush();
        end
        OP_INV: begin
          inv_idx_r = table_q[i].addr[INDEX_W-1:0];
          // memory model sends it at the next falling edge
          @(posedge clk_i);
          inv_go = 1'b1;
          do @(posedge clk_i); while (inv_go);
          @(negedge clk_i);
          fills[inv_idx_r] = 0;
        end
        default: begin
          @(negedge clk_i);
          en_i = table_q[i].addr[0];
          // enabling from disabled goes through a flush
          if (en_i && !en_model) begin
            wait_flush();
          end else begin
            @(negedge clk_i);
          end
          en_model = en_i;
        end
      endcase
      $display("test %0d %s %h: %s", i, table_q[i].op.name(), table_q[i].addr,
               (errors == e0) ? "pass" : "fail");
    end
    $display("%0d tests run, %0d checks failed", table_q.size(), errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb_icache_sva.sv ====
// icache controller checks
module icache_ctrl_sva import icache_pkg::*; (
  input logic        clk_i,
  input logic        rst_ni,
  input ctrl_state_e state_q,
  input logic        cmp_en_q,
  input way_mask_t   hit_i,
  input logic        mem_req_o,
  input logic        mem_ack_i,
  input mem_req_t    mem_req_data_o
);

  // the FSM only moves along its arcs, MISS only after an acknowledged request
  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != $past(state_q)) |->
      ((state_q == IDLE) ||
       (($past(state_q) == IDLE) && (state_q != MISS)) ||
       (($past(state_q) == READ) && (state_q == MISS) && $past(mem_ack_i))))
    else $error("illegal controller state change");

  a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_q |-> $onehot0(hit_i))
    else $error("more than one way hits");

  a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_req_data_o)))
    else $error("memory request dropped or changed before ack");

endmodule

bind icache_ctrl icache_ctrl_sva i_icache_ctrl_sva (.*);
